// ==== source/corr_cfg_pkg.sv ====
// Sizing constants and data types shared by the correlator datapath; import where needed.

package corr_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizing
  ////////////////////////////////////////////////////////////////////////////

  // parallel sample streams carried in one input word
  localparam int NUM_LANES = 4;

  // signed input sample
  localparam int SAMPLE_WIDTH = 6;

  // partial sums stay well inside this for 8 taps of 6-bit samples
  localparam int ACC_WIDTH = 12;

  // one lane field of the output word
  localparam int OUT_WIDTH = 16;

  localparam int LANE_WIDTH = $clog2(NUM_LANES);

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  typedef logic signed [ACC_WIDTH-1:0] acc_t;

  typedef logic signed [OUT_WIDTH-1:0] out_t;

  typedef logic [LANE_WIDTH-1:0] lane_t;

  // lane 0 sits in the low bits
  typedef sample_t [NUM_LANES-1:0] in_word_t;

  typedef out_t [NUM_LANES-1:0] out_word_t;

endpackage

// ==== source/corr_taps_pkg.sv ====
// Tap pattern type and the fixed table of correlator patterns; top level picks one entry.

package corr_taps_pkg;

  localparam int TAP_LENGTH = 8;

  localparam int NUM_PATTERNS = 4;

  // bit m belongs to tap m, which weights the sample from m words back
  // a 1 adds the sample and a 0 subtracts it
  typedef logic [TAP_LENGTH-1:0] tap_pattern_t;

  localparam tap_pattern_t TAP_PATTERNS [NUM_PATTERNS] = '{
    8'b1110_0010,
    8'b1011_0001,
    8'b0110_1101,
    // plain moving sum
    8'b1111_1111
  };

endpackage

// ==== source/lane_mem.sv ====
// Small per-lane store with one write port and a combinational read; payload type is a parameter.

`timescale 1ns/1ns

module lane_mem
  import corr_cfg_pkg::*;
#(
  parameter type payload_t = acc_t,
  parameter int  DEPTH     = NUM_LANES
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     wr_en,
  input  lane_t    wr_idx,
  input  payload_t wr_data,
  input  lane_t    rd_idx,
  output payload_t rd_data
);

  payload_t entries [DEPTH];

  // read sees the old entry on a same-cycle write to that lane
  assign rd_data = entries[rd_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        entries[i] <= '0;
      end
    end else if (wr_en) begin
      entries[wr_idx] <= wr_data;
    end
  end

  // lane index width must cover every entry
  a_idx_range: assert property (
    @(posedge clk) disable iff (reset)
    wr_en |-> (int'(wr_idx) < DEPTH)
  ) else $error("write to lane outside the store");

endmodule

// ==== source/lane_sequencer.sv ====
// Input side of the correlator; takes one word over valid/ready and issues its lanes in order.

`timescale 1ns/1ns

module lane_sequencer
  import corr_cfg_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     s_valid,
  output logic     s_ready,
  input  in_word_t s_data,
  input  logic     stall,
  output logic     lane_valid,
  output sample_t  lane_sample,
  output lane_t    lane_idx,
  output logic     lane_last
);

  localparam lane_t LAST_LANE = lane_t'(NUM_LANES - 1);

  in_word_t word_q;
  lane_t    lane_cnt;
  logic     busy;
  logic     armed;
  logic     accept;

  ////////////////////////////////////////////////////////////////////////////
  // lane issue
  ////////////////////////////////////////////////////////////////////////////

  assign lane_valid  = busy & ~stall;
  assign lane_idx    = lane_cnt;
  assign lane_sample = word_q[lane_cnt];
  assign lane_last   = busy & (lane_cnt == LAST_LANE);

  // a new word may land while the last lane of the current one goes out
  assign s_ready = armed & ~stall & (~busy | lane_last);
  assign accept  = s_valid & s_ready;

  // held low for the first cycle out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      armed <= 1'b0;
    end else begin
      armed <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      lane_cnt <= '0;
    end else if (accept) begin
      busy     <= 1'b1;
      lane_cnt <= '0;
    end else if (lane_valid) begin
      if (lane_last) begin
        busy     <= 1'b0;
        lane_cnt <= '0;
      end else begin
        lane_cnt <= lane_cnt + 1'b1;
      end
    end
  end

  // sample word
  always_ff @(posedge clk) begin
    if (accept) begin
      word_q <= s_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // a stalled or idle cycle must leave the lane pointer where it was
  a_idx_hold: assert property (
    @(posedge clk) disable iff (reset)
    !lane_valid |=> $stable(lane_idx)
  ) else $error("lane_idx moved without a lane strobe");

endmodule

// ==== source/bit_correlator.sv ====
// Shared time-multiplexed correlator core; one partial sum per lane at every tap stage.

`timescale 1ns/1ns

module bit_correlator
  import corr_cfg_pkg::*;
  import corr_taps_pkg::*;
#(
  parameter tap_pattern_t PATTERN = TAP_PATTERNS[0]
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    lane_valid,
  input  sample_t lane_sample,
  input  lane_t   lane_idx,
  input  logic    lane_last,
  output logic    res_valid,
  output acc_t    res_value,
  output lane_t   res_idx,
  output logic    res_last
);

  acc_t sample_ext;

  // stage_in[n] is what stage n got from stage n-1 on the lane's previous word
  acc_t stage_in  [TAP_LENGTH];
  acc_t stage_sum [TAP_LENGTH];

  assign sample_ext = acc_t'(lane_sample);

  ////////////////////////////////////////////////////////////////////////////
  // transposed tap chain
  ////////////////////////////////////////////////////////////////////////////

  // stage n applies tap TAP_LENGTH-1-n so the last stage carries tap 0
  // and the oldest sample has already walked through every other stage
  assign stage_in[0] = '0;

  for (genvar n = 0; n < TAP_LENGTH; n++) begin : g_stage
    localparam int TAP = TAP_LENGTH - 1 - n;

    assign stage_sum[n] = PATTERN[TAP] ? stage_in[n] + sample_ext
                                       : stage_in[n] - sample_ext;
  end

  // partial sums wait here for the same lane's next word
  for (genvar k = 0; k < TAP_LENGTH - 1; k++) begin : g_mem
    lane_mem #(
      .payload_t (acc_t),
      .DEPTH     (NUM_LANES)
    ) u_sum_mem (
      .clk     (clk),
      .reset   (reset),
      .wr_en   (lane_valid),
      .wr_idx  (lane_idx),
      .wr_data (stage_sum[k]),
      .rd_idx  (lane_idx),
      .rd_data (stage_in[k+1])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // result register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      res_valid <= 1'b0;
      res_last  <= 1'b0;
    end else begin
      res_valid <= lane_valid;
      res_last  <= lane_valid & lane_last;
    end
  end

  always_ff @(posedge clk) begin
    res_value <= stage_sum[TAP_LENGTH-1];
    res_idx   <= lane_idx;
  end

  // one cycle through the core with the lane tag carried along
  a_latency: assert property (
    @(posedge clk) disable iff (reset)
    lane_valid |=> res_valid && (res_idx == $past(lane_idx))
  ) else $error("result strobe missing one cycle after lane strobe");

endmodule

// ==== source/result_packer.sv ====
// Output side; gathers lane results of one word and presents the packed word over valid/ready.

`timescale 1ns/1ns

module result_packer
  import corr_cfg_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      res_valid,
  input  acc_t      res_value,
  input  lane_t     res_idx,
  input  logic      res_last,
  output logic      stall,
  output logic      m_valid,
  input  logic      m_ready,
  output out_word_t m_data
);

  out_t      rd_data;
  logic      drain_valid;
  lane_t     drain_idx;
  logic      drain_last;
  out_word_t gather_word;
  out_word_t gather_next;
  logic      word_full;
  logic      out_free;

  ////////////////////////////////////////////////////////////////////////////
  // collection
  ////////////////////////////////////////////////////////////////////////////

  // results land sign-extended and are read back the next cycle
  lane_mem #(
    .payload_t (out_t),
    .DEPTH     (NUM_LANES)
  ) u_collect (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (res_valid),
    .wr_idx  (res_idx),
    .wr_data (out_t'(res_value)),
    .rd_idx  (drain_idx),
    .rd_data (rd_data)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      drain_valid <= 1'b0;
      drain_last  <= 1'b0;
    end else begin
      drain_valid <= res_valid;
      drain_last  <= res_valid & res_last;
    end
  end

  always_ff @(posedge clk) begin
    drain_idx <= res_idx;
  end

  // gathered fields plus the one coming out of the store this cycle
  always_comb begin
    gather_next = gather_word;
    if (drain_valid) begin
      gather_next[drain_idx] = rd_data;
    end
  end

  always_ff @(posedge clk) begin
    gather_word <= gather_next;
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  assign out_free = ~m_valid | m_ready;

  // hold the sequencer once a finished word has nowhere to go
  assign stall = ~out_free & ((res_valid & res_last) | drain_last | word_full);

  always_ff @(posedge clk) begin
    if (reset) begin
      m_valid   <= 1'b0;
      word_full <= 1'b0;
    end else begin
      if (out_free) begin
        m_valid <= drain_last | word_full;
      end
      if (drain_last && !out_free) begin
        word_full <= 1'b1;
      end else if (out_free) begin
        word_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (out_free && (drain_last || word_full)) begin
      m_data <= gather_next;
    end
  end

  // back-pressure holds the word steady
  a_hold: assert property (
    @(posedge clk) disable iff (reset)
    m_valid && !m_ready |=> m_valid && $stable(m_data)
  ) else $error("output word changed under back-pressure");

  // the sequencer must have stopped in time for a waiting word
  a_no_overrun: assert property (
    @(posedge clk) disable iff (reset)
    word_full |-> !drain_valid
  ) else $error("lane result arrived over a waiting word");

endmodule

// ==== source/corr_top.sv ====
// Top level of the multi-lane bit correlator; connects sequencer, core and packer.

`timescale 1ns/1ns

module corr_top
  import corr_cfg_pkg::*;
  import corr_taps_pkg::*;
#(
  parameter int PATTERN_SEL = 0
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      s_valid,
  output logic      s_ready,
  input  in_word_t  s_data,
  output logic      m_valid,
  input  logic      m_ready,
  output out_word_t m_data
);

  // sequencer to core
  logic    lane_valid;
  sample_t lane_sample;
  lane_t   lane_idx;
  logic    lane_last;

  // core to packer
  logic    res_valid;
  acc_t    res_value;
  lane_t   res_idx;
  logic    res_last;

  logic    stall;

  lane_sequencer u_seq (
    .clk         (clk),
    .reset       (reset),
    .s_valid     (s_valid),
    .s_ready     (s_ready),
    .s_data      (s_data),
    .stall       (stall),
    .lane_valid  (lane_valid),
    .lane_sample (lane_sample),
    .lane_idx    (lane_idx),
    .lane_last   (lane_last)
  );

  bit_correlator #(
    .PATTERN (TAP_PATTERNS[PATTERN_SEL])
  ) u_core (
    .clk         (clk),
    .reset       (reset),
    .lane_valid  (lane_valid),
    .lane_sample (lane_sample),
    .lane_idx    (lane_idx),
    .lane_last   (lane_last),
    .res_valid   (res_valid),
    .res_value   (res_value),
    .res_idx     (res_idx),
    .res_last    (res_last)
  );

  result_packer u_pack (
    .clk       (clk),
    .reset     (reset),
    .res_valid (res_valid),
    .res_value (res_value),
    .res_idx   (res_idx),
    .res_last  (res_last),
    .stall     (stall),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .m_data    (m_data)
  );

endmodule

// ==== sim/corr_model.svh ====
// Reference model of the lane correlator and the compare tasks; included inside the testbench module.
`ifndef CORR_MODEL_SVH
`define CORR_MODEL_SVH

// newest sample of each lane sits at index 0
sample_t   hist [NUM_LANES][TAP_LENGTH];
out_word_t exp_q [$];

function automatic void clear_model();
  for (int l = 0; l < NUM_LANES; l++) begin
    for (int m = 0; m < TAP_LENGTH; m++) begin
      hist[l][m] = '0;
    end
  end
  exp_q.delete();
endfunction

// shift one accepted word into the history, return the expected output word
function automatic out_word_t step_model(input in_word_t w);
  out_word_t res;
  int        sum;
  for (int l = 0; l < NUM_LANES; l++) begin
    for (int m = TAP_LENGTH - 1; m > 0; m--) begin
      hist[l][m] = hist[l][m-1];
    end
    hist[l][0] = w[l];
    sum = 0;
    // tap m weights the sample from m words back
    for (int m = 0; m < TAP_LENGTH; m++) begin
      if (PATTERN[m]) begin
        sum += int'(hist[l][m]);
      end else begin
        sum -= int'(hist[l][m]);
      end
    end
    res[l] = out_t'(sum);
  end
  return res;
endfunction

task automatic compare_word(input string name, input out_word_t expected,
                            input out_word_t actual);
  if (actual !== expected) begin
    error_count++;
    $display("** Error: %s word %0d expected %h actual %h",
             name, words_out, expected, actual);
  end
endtask

task automatic compare_lane(input string name, input int lane, input out_t expected,
                            input out_t actual);
  if (actual !== expected) begin
    error_count++;
    $display("** Error: %s lane %0d expected %0d actual %0d",
             name, lane, expected, actual);
  end
endtask

`endif

// ==== sim/corr_tb.sv ====
// Testbench for the multi-lane bit correlator; random traffic checked against a model.

`timescale 1ns/1ns

module corr_tb
  import corr_cfg_pkg::*;
  import corr_taps_pkg::*;
();

  localparam int           CLK_PERIOD   = 40;
  // outputs are sampled this long after the falling edge
  localparam int           SETTLE       = CLK_PERIOD / 4;
  localparam int unsigned  SEED         = 32'h31b8_31c8;
  localparam int           PATTERN_SEL  = 2;
  localparam tap_pattern_t PATTERN      = TAP_PATTERNS[PATTERN_SEL];
  localparam int           BP_LEN       = 256;
  localparam int           SAMPLE_MIN   = -(1 << (SAMPLE_WIDTH - 1));
  localparam int           SAMPLE_MAX   = (1 << (SAMPLE_WIDTH - 1)) - 1;
  localparam int           N_RANDOM     = 40;
  localparam int           N_GAPS       = 30;
  localparam int           N_PRE_RESET  = 12;
  localparam int           N_POST_RESET = 20;

  // words sent by all tests together
  localparam int TOTAL_WORDS = (TAP_LENGTH + 2) + 2 * N_RANDOM + N_GAPS + 2 * TAP_LENGTH
                               + N_PRE_RESET + N_POST_RESET;
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * (NUM_LANES + 2) * 4;

  logic      clk;
  logic      reset;
  logic      s_valid;
  logic      s_ready;
  in_word_t  s_data;
  logic      m_valid;
  logic      m_ready;
  out_word_t m_data;

  logic      bp_on;
  logic      bp_bits [BP_LEN];
  int        bp_pos;
  string     cur_test;
  int        error_count;
  int        start_errors;
  int        tests_run;
  int        tests_ok;
  int        words_in;
  int        words_out;
  out_word_t got_q [$];

  `include "corr_model.svh"

  corr_top #(
    .PATTERN_SEL (PATTERN_SEL)
  ) UUT (
    .clk     (clk),
    .reset   (reset),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // output ready and monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (bp_on) begin
      m_ready = bp_bits[bp_pos];
      bp_pos  = (bp_pos + 1) % BP_LEN;
    end else begin
      m_ready = 1'b1;
    end
  end

  // handshakes seen here complete on the next rising edge
  always @(negedge clk) begin
    #(SETTLE);
    if (!reset) begin
      if (s_valid && s_ready) begin
        exp_q.push_back(step_model(s_data));
        words_in++;
      end
      if (m_valid && m_ready) begin
        if (exp_q.size() == 0) begin
          error_count++;
          $display("%s: output word delivered when none was expected", cur_test);
        end else begin
          compare_word(cur_test, exp_q.pop_front(), m_data);
        end
        got_q.push_back(m_data);
        words_out++;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("run timed out after %0d cycles in test %s", WATCHDOG_CYCLES, cur_test);
    $display("sim failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic in_word_t random_word();
    in_word_t w;
    for (int l = 0; l < NUM_LANES; l++) begin
      w[l] = sample_t'($urandom);
    end
    return w;
  endfunction

  function automatic in_word_t fill_word(input int value);
    in_word_t w;
    for (int l = 0; l < NUM_LANES; l++) begin
      w[l] = sample_t'(value);
    end
    return w;
  endfunction

  task automatic apply_reset();
    reset   = 1'b1;
    s_valid = 1'b0;
    clear_model();
    words_in  = 0;
    words_out = 0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    if (m_valid !== 1'b0 || s_ready !== 1'b0) begin
      error_count++;
      $display("%s: m_valid or s_ready not low after reset", cur_test);
    end
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_word(input in_word_t w);
    s_valid = 1'b1;
    s_data  = w;
    #(SETTLE);
    while (!s_ready) begin
      @(negedge clk);
      #(SETTLE);
    end
    @(negedge clk);
    s_valid = 1'b0;
  endtask

  task automatic drain_outputs();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    // a repeated word would show up within these cycles
    repeat (2 * (NUM_LANES + 2)) @(negedge clk);
    if (words_out != words_in) begin
      error_count++;
      $display("%s: %0d words accepted but %0d delivered", cur_test, words_in, words_out);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test     = name;
    start_errors = error_count;
    bp_on        = 1'b0;
    words_in     = 0;
    words_out    = 0;
    got_q.delete();
  endtask

  task automatic end_test();
    tests_run++;
    if (error_count == start_errors) begin
      tests_ok++;
      $display("test %s: ok, %0d words", cur_test, words_out);
    end else begin
      $display("test %s: %0d errors", cur_test, error_count - start_errors);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  // needs an all-zero history, so it runs straight after reset
  task automatic impulse_test();
    int expected;
    begin_test("impulse");
    send_word(fill_word(1));
    repeat (TAP_LENGTH + 1) send_word(fill_word(0));
    drain_outputs();
    if (got_q.size() != TAP_LENGTH + 2) begin
      error_count++;
      $display("%s: %0d words delivered instead of %0d", cur_test, got_q.size(),
               TAP_LENGTH + 2);
    end else begin
      for (int k = 0; k < TAP_LENGTH + 2; k++) begin
        expected = 0;
        if (k < TAP_LENGTH) begin
          expected = PATTERN[k] ? 1 : -1;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
          compare_lane(cur_test, l, out_t'(expected), got_q[k][l]);
        end
      end
    end
    end_test();
  endtask

  task automatic random_test(input string name, input int count, input logic bp,
                             input logic gaps);
    begin_test(name);
    bp_on = bp;
    for (int i = 0; i < count; i++) begin
      send_word(random_word());
      if (gaps) begin
        // the sequencer is busy NUM_LANES cycles per word, so it goes idle here
        repeat (NUM_LANES + $urandom % 4) @(negedge clk);
      end
    end
    drain_outputs();
    end_test();
  endtask

  // fill the history with the minimum, then walk the maximum in
  task automatic extremes_test();
    int sum;
    int npos;
    int value;
    begin_test("extremes");
    bp_on = 1'b1;
    repeat (TAP_LENGTH) send_word(fill_word(SAMPLE_MIN));
    repeat (TAP_LENGTH) send_word(fill_word(SAMPLE_MAX));
    drain_outputs();
    if (got_q.size() != 2 * TAP_LENGTH) begin
      error_count++;
      $display("%s: %0d words delivered instead of %0d", cur_test, got_q.size(),
               2 * TAP_LENGTH);
    end else begin
      for (int k = TAP_LENGTH - 1; k < 2 * TAP_LENGTH; k++) begin
        npos = k - TAP_LENGTH + 1;
        sum  = 0;
        for (int m = 0; m < TAP_LENGTH; m++) begin
          value = (m < npos) ? SAMPLE_MAX : SAMPLE_MIN;
          sum += PATTERN[m] ? value : -value;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
          compare_lane(cur_test, l, out_t'(sum), got_q[k][l]);
        end
      end
    end
    end_test();
  endtask

  task automatic reset_test();
    begin_test("mid_reset");
    bp_on = 1'b1;
    for (int i = 0; i < N_PRE_RESET; i++) begin
      send_word(random_word());
    end
    // words still in flight are dropped along with the model
    apply_reset();
    for (int i = 0; i < N_POST_RESET; i++) begin
      send_word(random_word());
    end
    drain_outputs();
    end_test();
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    s_valid     = 1'b0;
    s_data      = '0;
    m_ready     = 1'b1;
    bp_on       = 1'b0;
    bp_pos      = 0;
    cur_test    = "reset";
    error_count = 0;
    tests_run   = 0;
    tests_ok    = 0;
    void'($urandom(SEED));
    // about two thirds of the cycles ready
    for (int i = 0; i < BP_LEN; i++) begin
      bp_bits[i] = ($urandom % 3) != 0;
    end
    apply_reset();

    impulse_test();
    random_test("random_stream", N_RANDOM, 1'b0, 1'b0);
    random_test("backpressure", N_RANDOM, 1'b1, 1'b0);
    random_test("input_gaps", N_GAPS, 1'b0, 1'b1);
    extremes_test();
    reset_test();

    $display("tests run %0d, tests ok %0d, errors %0d", tests_run, tests_ok, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+sim
source/corr_cfg_pkg.sv
source/corr_taps_pkg.sv
source/lane_mem.sv
source/lane_sequencer.sv
source/bit_correlator.sv
source/result_packer.sv
source/corr_top.sv
sim/corr_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module corr_tb -f files.f -o corr_sim
	./obj_dir/corr_sim | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
